// ==== hw/player_pkg.sv ====
package player_pkg;

  // ============================================================
  // Sample format
  // ============================================================

  // One flash word carries two 16-bit halves
  parameter int HALF_W = 16;

  // Emitted sample is the upper byte of a half
  parameter int SAMPLE_W = 8;

  typedef logic signed [SAMPLE_W-1:0] sample_t;

  typedef logic [HALF_W-1:0] half_t;

  // ============================================================
  // Tempo divider
  // ============================================================

  typedef logic [15:0] tempo_div_t;

  // Clock cycles per playback tick, about 22 kHz at 50 MHz
  parameter tempo_div_t TEMPO_DIV_DEFAULT = 16'd2272;

  // Change applied per speed pulse
  parameter tempo_div_t TEMPO_DIV_STEP = 16'd100;

  // Fastest tempo allowed
  parameter tempo_div_t TEMPO_DIV_MIN = 16'd200;

  // Slowest tempo allowed
  parameter tempo_div_t TEMPO_DIV_MAX = 16'd10000;

endpackage

// ==== hw/flash_pkg.sv ====
package flash_pkg;

  // ============================================================
  // Flash bus geometry
  // ============================================================

  // Word address width of the flash bus
  parameter int ADDR_W = 23;

  // Data word width, two audio halves per word
  parameter int WORD_W = 32;

  typedef logic [ADDR_W-1:0] flash_addr_t;

  typedef logic [WORD_W-1:0] flash_word_t;

  // ============================================================
  // Sample region
  // ============================================================

  // Samples occupy words 0 up to this address
  parameter flash_addr_t FLASH_LAST_ADDR_DEFAULT = 23'h7FFFF;

endpackage

// ==== hw/playback_if.sv ====
`timescale 1ns/1ps

interface playback_if;

  // Captures the word returned by the flash
  logic load_word;

  // Emit the half that comes first in the current direction
  logic emit_first;

  // Emit the remaining half
  logic emit_second;

  // Advance the word address
  logic step_addr;

  modport ctrl (
    output load_word,
    output emit_first,
    output emit_second,
    output step_addr
  );

  modport buffer (
    input load_word,
    input emit_first,
    input emit_second
  );

  modport stepper (
    input step_addr
  );

endinterface

// ==== hw/tempo_timer.sv ====
`timescale 1ns/1ps

module tempo_timer #(
  parameter player_pkg::tempo_div_t DIV_DEFAULT = player_pkg::TEMPO_DIV_DEFAULT,
  parameter player_pkg::tempo_div_t DIV_STEP    = player_pkg::TEMPO_DIV_STEP,
  parameter player_pkg::tempo_div_t DIV_MIN     = player_pkg::TEMPO_DIV_MIN,
  parameter player_pkg::tempo_div_t DIV_MAX     = player_pkg::TEMPO_DIV_MAX
) (
  input  logic CLK_50M,
  input  logic mem_interp_control_wires,
  input  logic speed_up,
  input  logic speed_down,
  input  logic speed_reset,
  output logic tick
);

  player_pkg::tempo_div_t div_q;
  player_pkg::tempo_div_t cnt_q;
  logic                   speed_evt;

  // Any tempo request restarts the count
  assign speed_evt = speed_up | speed_down | speed_reset;

  // ============================================================
  // Divider register with clamping
  // ============================================================
  always_ff @(posedge CLK_50M or posedge mem_interp_control_wires)
  begin
    if (mem_interp_control_wires)
    begin
      div_q <= DIV_DEFAULT;
    end
    else if (speed_reset)
    begin
      div_q <= DIV_DEFAULT;
    end
    else if (speed_up)
    begin
      // Smaller divider means faster playback
      if (div_q < DIV_MIN + DIV_STEP)
        div_q <= DIV_MIN;
      else
        div_q <= div_q - DIV_STEP;
    end
    else if (speed_down)
    begin
      if (div_q > DIV_MAX - DIV_STEP)
        div_q <= DIV_MAX;
      else
        div_q <= div_q + DIV_STEP;
    end
  end

  // ============================================================
  // Free running tick counter
  // ============================================================
  always_ff @(posedge CLK_50M or posedge mem_interp_control_wires)
  begin
    if (mem_interp_control_wires)
    begin
      cnt_q <= '0;
      tick  <= 1'b0;
    end
    else if (speed_evt)
    begin
      cnt_q <= '0;
      tick  <= 1'b0;
    end
    else if (cnt_q == div_q - 1'b1)
    begin
      // One pulse per divider period
      cnt_q <= '0;
      tick  <= 1'b1;
    end
    else
    begin
      cnt_q <= cnt_q + 1'b1;
      tick  <= 1'b0;
    end
  end

endmodule

// ==== hw/flash_read_fsm.sv ====
`timescale 1ns/1ps

module flash_read_fsm (
  input  logic     CLK_50M,
  input  logic     mem_interp_control_wires,
  input  logic     tick,
  input  logic     pause,
  input  logic     flash_waitrequest,
  input  logic     flash_readdatavalid,
  output logic     flash_read,
  playback_if.ctrl ctrl
);

  typedef enum logic [2:0] {
    S_READ,
    S_WAIT_DATA,
    S_WAIT_FIRST,
    S_WAIT_SECOND,
    S_STEP
  } state_t;

  state_t state;
  logic   tick_ok;

  // Ticks only count while playing
  assign tick_ok = tick && !pause;

  // ============================================================
  // Strobes toward the data modules
  // ============================================================
  assign ctrl.load_word   = (state == S_WAIT_DATA) && flash_readdatavalid;
  assign ctrl.emit_first  = (state == S_WAIT_FIRST) && tick_ok;
  assign ctrl.emit_second = (state == S_WAIT_SECOND) && tick_ok;
  assign ctrl.step_addr   = (state == S_STEP);

  // ============================================================
  // State and read request
  // ============================================================
  always_ff @(posedge CLK_50M or posedge mem_interp_control_wires)
  begin
    if (mem_interp_control_wires)
    begin
      state      <= S_READ;
      flash_read <= 1'b0;
    end
    else
    begin
      case (state)
        S_READ:
        begin
          // Raise the request first, then hold it until accepted
          if (!flash_read)
          begin
            flash_read <= 1'b1;
          end
          else if (!flash_waitrequest)
          begin
            flash_read <= 1'b0;
            state      <= S_WAIT_DATA;
          end
        end
        S_WAIT_DATA:
        begin
          if (flash_readdatavalid)
            state <= S_WAIT_FIRST;
        end
        S_WAIT_FIRST:
        begin
          if (tick_ok)
            state <= S_WAIT_SECOND;
        end
        S_WAIT_SECOND:
        begin
          if (tick_ok)
            state <= S_STEP;
        end
        S_STEP:
        begin
          // Address moves this cycle, next request goes out with it
          flash_read <= 1'b1;
          state      <= S_READ;
        end
        default:
        begin
          flash_read <= 1'b0;
          state      <= S_READ;
        end
      endcase
    end
  end

endmodule

// ==== hw/address_stepper.sv ====
`timescale 1ns/1ps

module address_stepper #(
  parameter flash_pkg::flash_addr_t LAST_ADDR = flash_pkg::FLASH_LAST_ADDR_DEFAULT
) (
  input  logic                   CLK_50M,
  input  logic                   mem_interp_control_wires,
  input  logic                   direction,
  playback_if.stepper            stepper,
  output flash_pkg::flash_addr_t flash_address
);

  // ============================================================
  // Word address with wrap in both directions
  // ============================================================
  always_ff @(posedge CLK_50M or posedge mem_interp_control_wires)
  begin
    if (mem_interp_control_wires)
    begin
      flash_address <= '0;
    end
    else if (stepper.step_addr)
    begin
      if (direction)
      begin
        // Forward, end of region goes back to word 0
        if (flash_address == LAST_ADDR)
          flash_address <= '0;
        else
          flash_address <= flash_address + 1'b1;
      end
      else
      begin
        // Backward
        if (flash_address == '0)
          flash_address <= LAST_ADDR;
        else
          flash_address <= flash_address - 1'b1;
      end
    end
  end

endmodule

// ==== hw/sample_buffer.sv ====
`timescale 1ns/1ps

module sample_buffer (
  input  logic                   CLK_50M,
  input  logic                   mem_interp_control_wires,
  input  logic                   direction,
  input  flash_pkg::flash_word_t flash_readdata,
  playback_if.buffer             buffer,
  output player_pkg::sample_t    sample,
  output logic                   sample_valid
);

  flash_pkg::flash_word_t word_q;
  player_pkg::half_t      sel_half;
  logic                   take_low;
  logic                   emit;

  assign emit = buffer.emit_first | buffer.emit_second;

  // Forward plays low half first, backward plays high half first
  assign take_low = buffer.emit_first ? direction : !direction;

  assign sel_half = take_low ? word_q[player_pkg::HALF_W-1:0]
                             : word_q[2*player_pkg::HALF_W-1:player_pkg::HALF_W];

  // ============================================================
  // Data path
  // ============================================================
  always_ff @(posedge CLK_50M)
  begin
    if (buffer.load_word)
      word_q <= flash_readdata;
    if (emit)
      sample <= sel_half[player_pkg::HALF_W-1 -: player_pkg::SAMPLE_W];
  end

  // Valid follows the emit strobe by one cycle
  always_ff @(posedge CLK_50M or posedge mem_interp_control_wires)
  begin
    if (mem_interp_control_wires)
    begin
      sample_valid <= 1'b0;
    end
    else
    begin
      sample_valid <= emit;
    end
  end

endmodule

// ==== hw/flash_audio_player.sv ====
`timescale 1ns/1ps

module flash_audio_player #(
  parameter flash_pkg::flash_addr_t LAST_ADDR   = flash_pkg::FLASH_LAST_ADDR_DEFAULT,
  parameter player_pkg::tempo_div_t DIV_DEFAULT = player_pkg::TEMPO_DIV_DEFAULT,
  parameter player_pkg::tempo_div_t DIV_STEP    = player_pkg::TEMPO_DIV_STEP,
  parameter player_pkg::tempo_div_t DIV_MIN     = player_pkg::TEMPO_DIV_MIN,
  parameter player_pkg::tempo_div_t DIV_MAX     = player_pkg::TEMPO_DIV_MAX
) (
  input  logic                   CLK_50M,
  input  logic                   mem_interp_control_wires,
  input  logic                   direction,
  input  logic                   pause,
  input  logic                   speed_up,
  input  logic                   speed_down,
  input  logic                   speed_reset,
  // Flash read bus
  output logic                   flash_read,
  output flash_pkg::flash_addr_t flash_address,
  input  logic                   flash_waitrequest,
  input  flash_pkg::flash_word_t flash_readdata,
  input  logic                   flash_readdatavalid,
  // Audio out
  output player_pkg::sample_t    sample,
  output logic                   sample_valid
);

  logic tick;

  playback_if pb ();

  tempo_timer #(
    .DIV_DEFAULT (DIV_DEFAULT),
    .DIV_STEP    (DIV_STEP),
    .DIV_MIN     (DIV_MIN),
    .DIV_MAX     (DIV_MAX)
  ) tempo_timer_i (
    .CLK_50M                  (CLK_50M),
    .mem_interp_control_wires (mem_interp_control_wires),
    .speed_up                 (speed_up),
    .speed_down               (speed_down),
    .speed_reset              (speed_reset),
    .tick                     (tick)
  );

  flash_read_fsm flash_read_fsm_i (
    .CLK_50M                  (CLK_50M),
    .mem_interp_control_wires (mem_interp_control_wires),
    .tick                     (tick),
    .pause                    (pause),
    .flash_waitrequest        (flash_waitrequest),
    .flash_readdatavalid      (flash_readdatavalid),
    .flash_read               (flash_read),
    .ctrl                     (pb.ctrl)
  );

  address_stepper #(
    .LAST_ADDR (LAST_ADDR)
  ) address_stepper_i (
    .CLK_50M                  (CLK_50M),
    .mem_interp_control_wires (mem_interp_control_wires),
    .direction                (direction),
    .stepper                  (pb.stepper),
    .flash_address            (flash_address)
  );

  sample_buffer sample_buffer_i (
    .CLK_50M                  (CLK_50M),
    .mem_interp_control_wires (mem_interp_control_wires),
    .direction                (direction),
    .flash_readdata           (flash_readdata),
    .buffer                   (pb.buffer),
    .sample                   (sample),
    .sample_valid             (sample_valid)
  );

endmodule

// ==== verification/flash_model.sv ====
`timescale 1ns/1ps

module flash_model #(
  parameter int DEPTH = 16
) (
  input  logic                   clk,
  input  logic                   flash_read,
  input  flash_pkg::flash_addr_t flash_address,
  output logic                   flash_waitrequest,
  output flash_pkg::flash_word_t flash_readdata,
  output logic                   flash_readdatavalid
);

  flash_pkg::flash_word_t mem [DEPTH];
  logic [15:0]            lfsr_q;

  // Galois LFSR, taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++)
    begin
      value  = {value[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // Outputs change 2 ns after the rising edge
  task automatic wait_cycles(input logic [31:0] n);
    repeat (n)
    begin
      @(posedge clk);
      #2;
    end
  endtask

  initial
  begin : serve
    logic [31:0]            lat;
    flash_pkg::flash_addr_t addr;
    lfsr_q              = 16'd13;
    flash_waitrequest   = 1'b1;
    flash_readdatavalid = 1'b0;
    flash_readdata      = '0;
    for (int w = 0; w < DEPTH; w++)
      take_bits(32, mem[w]);
    forever
    begin
      @(posedge clk);
      #2;
      if (flash_read)
      begin
        addr = flash_address;
        take_bits(2, lat);
        wait_cycles(lat);
        flash_waitrequest = 1'b0;
        // Request accepted on this edge
        wait_cycles(1);
        flash_waitrequest = 1'b1;
        take_bits(2, lat);
        wait_cycles(lat);
        // Out of range reads return a marked word
        flash_readdata      = (addr < DEPTH) ? mem[addr] : {9'h1A5, addr};
        flash_readdatavalid = 1'b1;
        wait_cycles(1);
        flash_readdatavalid = 1'b0;
      end
    end
  end

endmodule

// ==== verification/tb_flash_audio_player.sv ====
`timescale 1ns/1ps

module tb_flash_audio_player;

  localparam flash_pkg::flash_addr_t LAST_ADDR   = 23'd15;
  localparam player_pkg::tempo_div_t DIV_DEFAULT = 16'd40;
  localparam player_pkg::tempo_div_t DIV_STEP    = 16'd8;
  localparam player_pkg::tempo_div_t DIV_MIN     = 16'd16;
  localparam player_pkg::tempo_div_t DIV_MAX     = 16'd80;
  localparam int WORDS             = 16;
  localparam int SAMPLES_REQUESTED = 120;
  localparam int TIMEOUT_CYCLES    = SAMPLES_REQUESTED * int'(DIV_MAX) + 1000;
  localparam int TEMPO_UP    = 0;
  localparam int TEMPO_DOWN  = 1;
  localparam int TEMPO_RESET = 2;

  logic                   CLK_50M;
  logic                   mem_interp_control_wires;
  logic                   direction;
  logic                   pause;
  logic                   speed_up;
  logic                   speed_down;
  logic                   speed_reset;
  logic                   flash_read;
  flash_pkg::flash_addr_t flash_address;
  logic                   flash_waitrequest;
  flash_pkg::flash_word_t flash_readdata;
  logic                   flash_readdatavalid;
  player_pkg::sample_t    sample;
  logic                   sample_valid;

  flash_pkg::flash_word_t ref_words [WORDS];
  player_pkg::tempo_div_t exp_div = DIV_DEFAULT;
  player_pkg::tempo_div_t interval;
  int   exp_idx = 0;
  int   exp_pos = 0;
  int   samples_done = 0;
  int   words_done = 0;
  int   cycle_cnt = 0;
  int   first_cycle = 0;
  logic span_clean = 1'b0;

  flash_audio_player #(
    .LAST_ADDR   (LAST_ADDR),
    .DIV_DEFAULT (DIV_DEFAULT),
    .DIV_STEP    (DIV_STEP),
    .DIV_MIN     (DIV_MIN),
    .DIV_MAX     (DIV_MAX)
  ) flash_audio_player_i (.*);

  flash_model #(.DEPTH(WORDS)) flash_model_i (.clk(CLK_50M), .*);

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // ============================================================
  // Reference rules
  // ============================================================

  // Upper byte of the half played at this position of the word
  function automatic player_pkg::sample_t expected_sample(input int idx, input int pos,
                                                          input logic dir);
    player_pkg::half_t half;
    if ((pos == 0 && dir) || (pos == 1 && !dir))
      half = ref_words[idx][15:0];
    else
      half = ref_words[idx][31:16];
    return half[15:8];
  endfunction

  function automatic int next_index(input int idx, input logic dir);
    if (dir)
      return (idx == int'(LAST_ADDR)) ? 0 : idx + 1;
    return (idx == 0) ? int'(LAST_ADDR) : idx - 1;
  endfunction

  function automatic player_pkg::tempo_div_t next_div(input player_pkg::tempo_div_t cur,
                                                      input int kind);
    int v;
    case (kind)
      TEMPO_UP:   v = int'(cur) - int'(DIV_STEP);
      TEMPO_DOWN: v = int'(cur) + int'(DIV_STEP);
      default:    v = int'(DIV_DEFAULT);
    endcase
    if (v < int'(DIV_MIN))
      v = int'(DIV_MIN);
    if (v > int'(DIV_MAX))
      v = int'(DIV_MAX);
    return 16'(v);
  endfunction

  // ============================================================
  // Checks
  // ============================================================
  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_sample(input player_pkg::sample_t got, input player_pkg::sample_t exp);
    if (got !== exp)
      stop_with_failure($sformatf("error sample: got 0x%0h expected 0x%0h", got, exp));
  endtask

  task automatic check_interval(input player_pkg::tempo_div_t got,
                                input player_pkg::tempo_div_t exp);
    if (got !== exp)
      stop_with_failure($sformatf("error sample_valid interval: got 0x%0h expected 0x%0h",
                                  got, exp));
  endtask

  task automatic check_addr(input flash_pkg::flash_addr_t got, input flash_pkg::flash_addr_t exp);
    if (got !== exp)
      stop_with_failure($sformatf("error flash_address: got 0x%0h expected 0x%0h", got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_with_failure($sformatf("error %s: got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic check_idle();
    check_bit("sample_valid", sample_valid, 1'b0);
    check_bit("flash_read", flash_read, 1'b0);
    check_addr(flash_address, '0);
  endtask

  // Compare every sample with the expected sequence
  always @(posedge CLK_50M)
  begin
    #1;
    cycle_cnt++;
    if (mem_interp_control_wires)
    begin
      exp_idx    = 0;
      exp_pos    = 0;
      span_clean = 1'b0;
    end
    else
    begin
      if (sample_valid)
      begin
        check_sample(sample, expected_sample(exp_idx, exp_pos, direction));
        samples_done++;
        if (exp_pos == 0)
        begin
          first_cycle = cycle_cnt;
          span_clean  = 1'b1;
          exp_pos     = 1;
        end
        else
        begin
          if (span_clean)
          begin
            interval = 16'(cycle_cnt - first_cycle);
            check_interval(interval, exp_div);
          end
          exp_idx = next_index(exp_idx, direction);
          exp_pos = 0;
          words_done++;
        end
      end
      // Pause or a tempo pulse between the halves spoils the interval
      if (pause || speed_up || speed_down || speed_reset)
        span_clean = 1'b0;
    end
  end

  // ============================================================
  // Stimulus
  // ============================================================
  task automatic apply_reset();
    mem_interp_control_wires = 1'b1;
    exp_div = DIV_DEFAULT;
    repeat (5)
    begin
      @(posedge CLK_50M);
      #1;
      check_idle();
      #1;
    end
    mem_interp_control_wires = 1'b0;
    #1;
    check_idle();
    // First read goes out on the first clock
    @(posedge CLK_50M);
    #1;
    check_bit("flash_read", flash_read, 1'b1);
    check_addr(flash_address, '0);
    #1;
  endtask

  task automatic tempo_pulse(input int kind);
    speed_up    = (kind == TEMPO_UP);
    speed_down  = (kind == TEMPO_DOWN);
    speed_reset = (kind == TEMPO_RESET);
    exp_div     = next_div(exp_div, kind);
    @(posedge CLK_50M);
    #2;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    @(posedge CLK_50M);
    #2;
  endtask

  task automatic wait_samples(input int n);
    int target;
    target = samples_done + n;
    while (samples_done < target)
      @(posedge CLK_50M);
    #2;
  endtask

  // Returns one cycle after the second half of a word
  task automatic wait_words(input int n);
    int target;
    target = words_done + n;
    while (words_done < target)
      @(posedge CLK_50M);
    #2;
  endtask

  task automatic wait_first_half();
    int target;
    target = samples_done + 1;
    while (samples_done < target || exp_pos != 1)
      @(posedge CLK_50M);
    #2;
  endtask

  initial
  begin : stimulus
    mem_interp_control_wires = 1'b1;
    direction   = 1'b1;
    pause       = 1'b0;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    #1;
    for (int i = 0; i < WORDS; i++)
      ref_words[i] = flash_model_i.mem[i];
    apply_reset();
    // Forward through the wrap from word 15 to word 0
    wait_samples(40);
    wait_words(1);
    direction = 1'b0;
    wait_samples(40);
    pause = 1'b1;
    repeat (200)
    begin
      @(posedge CLK_50M);
      #1;
      if (sample_valid)
        stop_with_failure("sample_valid pulsed while pause was high");
      #1;
    end
    pause = 1'b0;
    wait_samples(6);
    // Tempo changes at word boundaries
    wait_words(1);
    direction = 1'b1;
    tempo_pulse(TEMPO_UP);
    wait_words(3);
    repeat (4)
      tempo_pulse(TEMPO_UP);
    wait_words(3);
    tempo_pulse(TEMPO_RESET);
    tempo_pulse(TEMPO_DOWN);
    wait_words(3);
    // Restart in mid word
    wait_first_half();
    apply_reset();
    wait_samples(8);
    $display("Simulation finished: PASS");
    $finish;
  end

  initial
  begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge CLK_50M);
    stop_with_failure("timeout, playback did not finish in the expected time");
  end

endmodule

// ==== sim.f ====
hw/player_pkg.sv
hw/flash_pkg.sv
hw/playback_if.sv
hw/tempo_timer.sv
hw/flash_read_fsm.sv
hw/address_stepper.sv
hw/sample_buffer.sv
hw/flash_audio_player.sv
verification/flash_model.sv
verification/tb_flash_audio_player.sv

// ==== Makefile ====
BIN := obj_dir/Vtb_flash_audio_player

.PHONY: all run clean

all: run

# Rebuilt only when the file list or a source changes
$(BIN): sim.f $(shell cat sim.f)
	verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_flash_audio_player

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
